// File: hw/zero_fir_defs.svh
`ifndef ZERO_FIR_DEFS_SVH
`define ZERO_FIR_DEFS_SVH

////////////////////////////////////////
// Datapath geometry
////////////////////////////////////////

// Samples handled on every clock
`define ZF_NSAMP 4

// Input, output and coefficient widths
`define ZF_NBITS 12
`define ZF_OBITS 16
`define ZF_CBITS 18

// Fixed point, 0x4000 is unity gain
`define ZF_CFRAC 14
// Output keeps 4 fraction bits over the input
`define ZF_OFRAC 4

////////////////////////////////////////
// Bus map
////////////////////////////////////////

`define ZF_ABITS 7
`define ZF_DBITS 32

// Control and write count
`define ZF_ADR_CTRL 7'h0
// Coefficient staging chain
`define ZF_ADR_COEF 7'h4

`endif

// File: hw/coef_bus_pkg.sv
`include "zero_fir_defs.svh"

package coef_bus_pkg;

    ////////////////////////////////////////
    // Bus words
    ////////////////////////////////////////

    typedef logic [`ZF_ABITS-1:0] bus_adr_t;
    typedef logic [`ZF_DBITS-1:0] bus_dat_t;

    // Word written to the coefficient address
    // Coefficient sits right justified
    typedef struct packed {
        logic [`ZF_DBITS-`ZF_CBITS-1:0] pad;
        logic [`ZF_CBITS-1:0]           coef;
    } coef_word_t;

    // Word written to the control address
    typedef struct packed {
        logic [`ZF_DBITS-2:0] rsvd;
        logic                 update;   // Copy staged set to active set
    } ctrl_word_t;

    // Same write word, seen two ways depending on address
    typedef union packed {
        coef_word_t coef_word;
        ctrl_word_t ctrl_word;
    } bus_word_u;

endpackage

// File: hw/sample_pkg.sv
`include "zero_fir_defs.svh"

package sample_pkg;

    ////////////////////////////////////////
    // Sample side
    ////////////////////////////////////////

    // Raw input sample, integer
    typedef logic signed [`ZF_NBITS-1:0] sample_t;

    // Shaped output sample, 4 fraction bits
    typedef logic signed [`ZF_OBITS-1:0] out_sample_t;

    ////////////////////////////////////////
    // Arithmetic side
    ////////////////////////////////////////

    // Coefficient, 14 fraction bits
    typedef logic signed [`ZF_CBITS-1:0] coef_t;

    // Full precision sample times coefficient
    typedef logic signed [`ZF_NBITS+`ZF_CBITS-1:0] prod_t;

    // Two products summed, one guard bit
    typedef logic signed [`ZF_NBITS+`ZF_CBITS:0] acc_t;

endpackage

// File: hw/coef_regfile.sv
`timescale 1ns/10ps
`include "zero_fir_defs.svh"

module coef_regfile
    import coef_bus_pkg::*;
    import sample_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    input  bus_adr_t wb_adr_i,
    input  bus_dat_t wb_dat_i,
    output logic     wb_ack_o,
    output bus_dat_t wb_dat_o,
    output coef_t    b0_o [`ZF_NSAMP],
    output coef_t    b1_o [`ZF_NSAMP]
);

    // Two coefficients per lane
    localparam int NCOEF    = 2 * `ZF_NSAMP;
    localparam int CNT_BITS = 8;
    localparam coef_t UNITY = coef_t'(1 << `ZF_CFRAC);

    logic                req;
    logic                req_new;
    logic                coef_wr;
    logic                ctrl_wr;
    logic                do_update;
    bus_word_u           wr_word;
    coef_t               stage_q [NCOEF];
    logic [CNT_BITS-1:0] wr_cnt_q;

    ////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////

    assign req = wb_cyc_i & wb_stb_i;
    // Only the first cycle of a request, ack not yet out
    assign req_new = req & ~wb_ack_o;

    assign wr_word   = wb_dat_i;
    assign coef_wr   = req_new & wb_we_i & (wb_adr_i == `ZF_ADR_COEF);
    assign ctrl_wr   = req_new & wb_we_i & (wb_adr_i == `ZF_ADR_CTRL);
    assign do_update = ctrl_wr & wr_word.ctrl_word.update;

    // One cycle ack, writes land on this same edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req_new;
        end
    end

    // Read data valid alongside ack
    // Control address gives write count, rest reads zero
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_dat_o <= '0;
        end else if (req_new && !wb_we_i && (wb_adr_i == `ZF_ADR_CTRL)) begin
            wb_dat_o <= bus_dat_t'(wr_cnt_q);
        end else begin
            wb_dat_o <= '0;
        end
    end

    ////////////////////////////////////////
    // Staging chain and count
    ////////////////////////////////////////

    // Newest write enters position 0
    // Even slots b0, odd slots b1 once full
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NCOEF; i++) begin
                stage_q[i] <= (i % 2 == 0) ? UNITY : '0;
            end
        end else if (coef_wr) begin
            stage_q[0] <= coef_t'(wr_word.coef_word.coef);
            for (int i = 1; i < NCOEF; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // Writes since last update
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_cnt_q <= '0;
        end else if (do_update) begin
            wr_cnt_q <= '0;
        end else if (coef_wr) begin
            wr_cnt_q <= wr_cnt_q + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Active set
    ////////////////////////////////////////

    // Identity filter out of reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int k = 0; k < `ZF_NSAMP; k++) begin
                b0_o[k] <= UNITY;
                b1_o[k] <= '0;
            end
        end else if (do_update) begin
            for (int k = 0; k < `ZF_NSAMP; k++) begin
                b0_o[k] <= stage_q[2*k];
                b1_o[k] <= stage_q[2*k+1];
            end
        end
    end

endmodule

// File: hw/zero_fir.sv
`timescale 1ns/10ps
`include "zero_fir_defs.svh"

module zero_fir
    import sample_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  sample_t dat_i [`ZF_NSAMP],
    input  logic    bypass_i,
    input  coef_t   b0_i [`ZF_NSAMP],
    input  coef_t   b1_i [`ZF_NSAMP],
    output acc_t    acc_o [`ZF_NSAMP],
    output sample_t raw_o [`ZF_NSAMP],
    output logic    bypass_o
);

    // Lane feeding the next frame's lane 0
    localparam int LAST = `ZF_NSAMP - 1;

    sample_t x_q    [`ZF_NSAMP];
    sample_t hist_q;
    sample_t x_prev [`ZF_NSAMP];
    prod_t   p0_q   [`ZF_NSAMP];
    prod_t   p1_q   [`ZF_NSAMP];
    sample_t raw_q  [`ZF_NSAMP];
    logic    byp_q0;
    logic    byp_q1;

    ////////////////////////////////////////
    // Stage 0, input and history
    ////////////////////////////////////////

    // Input reg is the history source
    // Cleared so history starts at zero
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `ZF_NSAMP; i++) begin
                x_q[i] <= '0;
            end
            hist_q <= '0;
            byp_q0 <= 1'b0;
        end else begin
            x_q    <= dat_i;
            hist_q <= x_q[LAST];
            byp_q0 <= bypass_i;
        end
    end

    // x[n-1] per lane
    // Lane 0 reaches back into the previous frame
    always_comb begin
        x_prev[0] = hist_q;
        for (int i = 1; i < `ZF_NSAMP; i++) begin
            x_prev[i] = x_q[i-1];
        end
    end

    ////////////////////////////////////////
    // Stage 1, products
    ////////////////////////////////////////

    // Uses whatever active set is present now
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ZF_NSAMP; i++) begin
            p0_q[i]  <= x_q[i] * b0_i[i];
            p1_q[i]  <= x_prev[i] * b1_i[i];
            raw_q[i] <= x_q[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            byp_q1 <= 1'b0;
        end else begin
            byp_q1 <= byp_q0;
        end
    end

    ////////////////////////////////////////
    // Stage 2, sums
    ////////////////////////////////////////

    // Guard bit absorbs the add
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ZF_NSAMP; i++) begin
            acc_o[i] <= p0_q[i] + p1_q[i];
            raw_o[i] <= raw_q[i];
        end
    end

    // Bypass flag kept in step with the sums
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bypass_o <= 1'b0;
        end else begin
            bypass_o <= byp_q1;
        end
    end

endmodule

// File: hw/output_shaper.sv
`timescale 1ns/10ps
`include "zero_fir_defs.svh"

module output_shaper
    import sample_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  acc_t        acc_i [`ZF_NSAMP],
    input  sample_t     raw_i [`ZF_NSAMP],
    input  logic        bypass_i,
    output out_sample_t dat_o [`ZF_NSAMP]
);

    // Drop coefficient fraction, keep output fraction
    localparam int SHIFT   = `ZF_CFRAC - `ZF_OFRAC;
    // One extra bit so the rounding add cannot wrap
    localparam int RW      = $bits(acc_t) + 1;
    localparam int HALF    = 1 << (SHIFT - 1);
    localparam int SAT_MAX = (1 << (`ZF_OBITS - 1)) - 1;
    localparam int SAT_MIN = -(1 << (`ZF_OBITS - 1));

    logic signed [RW-1:0] rnd    [`ZF_NSAMP];
    logic signed [RW-1:0] scaled [`ZF_NSAMP];
    out_sample_t          sat    [`ZF_NSAMP];
    out_sample_t          byp    [`ZF_NSAMP];

    ////////////////////////////////////////
    // Round, scale, clip
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `ZF_NSAMP; i++) begin
            // Round half up before the arithmetic shift
            rnd[i]    = acc_i[i] + RW'(HALF);
            scaled[i] = rnd[i] >>> SHIFT;

            // Clip to 16 bit range
            if (scaled[i] > SAT_MAX) begin
                sat[i] = out_sample_t'(SAT_MAX);
            end else if (scaled[i] < SAT_MIN) begin
                sat[i] = out_sample_t'(SAT_MIN);
            end else begin
                sat[i] = out_sample_t'(scaled[i]);
            end

            // Bypass path lines up with the output fraction
            byp[i] = out_sample_t'(raw_i[i]) <<< `ZF_OFRAC;
        end
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    // Whole frame takes one path or the other
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `ZF_NSAMP; i++) begin
                dat_o[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `ZF_NSAMP; i++) begin
                dat_o[i] <= bypass_i ? byp[i] : sat[i];
            end
        end
    end

endmodule

// File: hw/zero_fir_top.sv
`timescale 1ns/10ps
`include "zero_fir_defs.svh"

module zero_fir_top
    import coef_bus_pkg::*;
    import sample_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  bus_adr_t    wb_adr_i,
    input  bus_dat_t    wb_dat_i,
    output logic        wb_ack_o,
    output bus_dat_t    wb_dat_o,
    input  logic        bypass_i,
    input  sample_t     dat_i [`ZF_NSAMP],
    output out_sample_t dat_o [`ZF_NSAMP]
);

    // Active coefficients
    coef_t   b0 [`ZF_NSAMP];
    coef_t   b1 [`ZF_NSAMP];
    // FIR to shaper
    acc_t    acc [`ZF_NSAMP];
    sample_t raw [`ZF_NSAMP];
    logic    byp;

    // Bus side, coefficient storage
    coef_regfile u_regfile (
        .clk      (clk),
        .reset_i  (reset_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_ack_o (wb_ack_o),
        .wb_dat_o (wb_dat_o),
        .b0_o     (b0),
        .b1_o     (b1)
    );

    // Two tap FIR, three register stages
    zero_fir u_fir (
        .clk      (clk),
        .reset_i  (reset_i),
        .dat_i    (dat_i),
        .bypass_i (bypass_i),
        .b0_i     (b0),
        .b1_i     (b1),
        .acc_o    (acc),
        .raw_o    (raw),
        .bypass_o (byp)
    );

    // Round, clip or bypass
    output_shaper u_shaper (
        .clk      (clk),
        .reset_i  (reset_i),
        .acc_i    (acc),
        .raw_i    (raw),
        .bypass_i (byp),
        .dat_o    (dat_o)
    );

endmodule

// File: verification/zero_fir_assert.sv
`timescale 1ns/10ps
`include "zero_fir_defs.svh"

module zero_fir_assert
    import sample_pkg::*;
(
    input logic        clk,
    input logic        reset_i,
    input logic        cyc_i,
    input logic        stb_i,
    input logic        ack_i,
    input out_sample_t dat_i [`ZF_NSAMP]
);

    int unsigned fail_cnt;
    logic        dat_zero;
    logic [1:0]  since_rst;

    initial fail_cnt = 0;

    // Whole output frame is zero
    always_comb begin
        dat_zero = 1'b1;
        for (int i = 0; i < `ZF_NSAMP; i++) begin
            if (dat_i[i] != '0) begin
                dat_zero = 1'b0;
            end
        end
    end

    // Cycles since reset released, stops at 3
    always_ff @(posedge clk) begin
        if (reset_i) begin
            since_rst <= 2'd0;
        end else if (since_rst != 2'd3) begin
            since_rst <= since_rst + 2'd1;
        end
    end

    ////////////////////////////////////////
    // Bus handshake
    ////////////////////////////////////////

    // Ack is a single cycle pulse
    ack_single: assert property (@(posedge clk) disable iff (reset_i)
        ack_i |=> !ack_i)
        else begin
            fail_cnt++;
            $error("ack high for more than one cycle");
        end

    // Ack only follows a request
    ack_has_req: assert property (@(posedge clk) disable iff (reset_i)
        ack_i |-> $past(cyc_i && stb_i))
        else begin
            fail_cnt++;
            $error("ack without a request");
        end

    ////////////////////////////////////////
    // Pipeline after reset
    ////////////////////////////////////////

    // Nothing real reaches the output for three edges
    out_clear: assert property (@(posedge clk)
        (!reset_i && since_rst != 2'd3) |-> dat_zero)
        else begin
            fail_cnt++;
            $error("output not zero right after reset");
        end

endmodule

bind zero_fir_top zero_fir_assert u_assert (
    .clk     (clk),
    .reset_i (reset_i),
    .cyc_i   (wb_cyc_i),
    .stb_i   (wb_stb_i),
    .ack_i   (wb_ack_o),
    .dat_i   (dat_o)
);

// File: verification/zero_fir_tb.sv
`timescale 1ns/10ps
`include "zero_fir_defs.svh"

module zero_fir_tb
    import coef_bus_pkg::*;
    import sample_pkg::*;
();

    localparam int NCOEF       = 2 * `ZF_NSAMP;
    localparam int LAT         = 3;
    localparam int ACK_TIMEOUT = 16;
    localparam int FW          = `ZF_NSAMP * `ZF_OBITS;
    localparam int PADW        = `ZF_DBITS - `ZF_CBITS;
    localparam int RSVW        = `ZF_DBITS - 1;
    localparam int OUT_MAX     = 32767;
    localparam int OUT_MIN     = -32768;
    localparam int SMAX        = (1 << (`ZF_NBITS - 1)) - 1;
    localparam int SMIN        = -(1 << (`ZF_NBITS - 1));

    logic        clk;
    logic        reset_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    bus_adr_t    wb_adr_i;
    bus_dat_t    wb_dat_i;
    logic        wb_ack_o;
    bus_dat_t    wb_dat_o;
    logic        bypass_i;
    sample_t     dat_i [`ZF_NSAMP];
    out_sample_t dat_o [`ZF_NSAMP];

    // Model copy of coefficients, staging chain and history
    int            m_b0    [`ZF_NSAMP];
    int            m_b1    [`ZF_NSAMP];
    int            m_stage [NCOEF];
    int            m_hist;
    int            m_cnt;
    logic [FW-1:0] exp_q   [$];

    zero_fir_top dut (
        .clk      (clk),
        .reset_i  (reset_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_ack_o (wb_ack_o),
        .wb_dat_o (wb_dat_o),
        .bypass_i (bypass_i),
        .dat_i    (dat_i),
        .dat_o    (dat_o)
    );

    // 4 ns period
    initial clk = 1'b0;
    always #2 clk = ~clk;

    ////////////////////////////////////////
    // Checking
    ////////////////////////////////////////

    task automatic check_value(input string what, input int got, input int expected);
        if (got !== expected) begin
            $display("Error at %0.1f ns: %s is %0d, expected %0d",
                     $realtime, what, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped");
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // y = b0*x[n] + b1*x[n-1], round, clip, or x << 4 in bypass
    task automatic model_frame(input sample_t f [`ZF_NSAMP], input logic byp);
        logic [FW-1:0] word;
        longint        acc;
        longint        r;
        int            x;
        int            xp;
        int            y;
        word = '0;
        for (int i = 0; i < `ZF_NSAMP; i++) begin
            x = int'(f[i]);
            if (i == 0) begin
                xp = m_hist;
            end else begin
                xp = int'(f[i-1]);
            end
            if (byp) begin
                y = x * 16;
            end else begin
                acc = longint'(x) * m_b0[i] + longint'(xp) * m_b1[i];
                r   = (acc + 512) >>> 10;
                if (r > OUT_MAX) begin
                    y = OUT_MAX;
                end else if (r < OUT_MIN) begin
                    y = OUT_MIN;
                end else begin
                    y = int'(r);
                end
            end
            word[i*`ZF_OBITS +: `ZF_OBITS] = 16'(y);
        end
        // History runs on in bypass too
        m_hist = int'(f[`ZF_NSAMP-1]);
        exp_q.push_back(word);
    endtask

    ////////////////////////////////////////
    // Stream driving
    ////////////////////////////////////////

    // One frame per cycle, output checked three frames later
    task automatic drive_frame(input sample_t f [`ZF_NSAMP], input logic byp);
        logic [FW-1:0] word;
        dat_i    = f;
        bypass_i = byp;
        model_frame(f, byp);
        @(posedge clk);
        #0.5;
        if (exp_q.size() > LAT) begin
            word = exp_q.pop_front();
            for (int i = 0; i < `ZF_NSAMP; i++) begin
                check_value($sformatf("dat_o lane %0d", i), int'(dat_o[i]),
                            int'($signed(word[i*`ZF_OBITS +: `ZF_OBITS])));
            end
        end
    endtask

    task automatic idle_cycle();
        sample_t f [`ZF_NSAMP];
        for (int i = 0; i < `ZF_NSAMP; i++) begin
            f[i] = '0;
        end
        drive_frame(f, 1'b0);
    endtask

    task automatic run_random(input int n, input bit byp_en);
        sample_t f [`ZF_NSAMP];
        logic    byp;
        for (int k = 0; k < n; k++) begin
            for (int i = 0; i < `ZF_NSAMP; i++) begin
                f[i] = sample_t'($urandom);
            end
            byp = byp_en && ($urandom_range(1) == 1);
            drive_frame(f, byp);
        end
    endtask

    // Mode 0 all max, 1 all min, 2 mixed per lane
    task automatic run_fullscale(input int n, input int mode);
        sample_t f [`ZF_NSAMP];
        for (int k = 0; k < n; k++) begin
            for (int i = 0; i < `ZF_NSAMP; i++) begin
                if (mode == 0 || (mode == 2 && $urandom_range(1) == 1)) begin
                    f[i] = sample_t'(SMAX);
                end else begin
                    f[i] = sample_t'(SMIN);
                end
            end
            drive_frame(f, 1'b0);
        end
    endtask

    ////////////////////////////////////////
    // Bus master
    ////////////////////////////////////////

    task automatic bus_write(input bus_adr_t adr, input bus_dat_t dat);
        int waited;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = adr;
        wb_dat_i = dat;
        waited   = 0;
        do begin
            idle_cycle();
            waited++;
            if (waited > ACK_TIMEOUT) begin
                abort_run("Timeout: no bus ack for a write");
            end
        end while (!wb_ack_o);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        // Model follows the write on its ack
        if (adr == `ZF_ADR_COEF) begin
            for (int j = NCOEF - 1; j > 0; j--) begin
                m_stage[j] = m_stage[j-1];
            end
            m_stage[0] = int'($signed(dat[`ZF_CBITS-1:0]));
            m_cnt++;
        end else if (adr == `ZF_ADR_CTRL && dat[0]) begin
            for (int k = 0; k < `ZF_NSAMP; k++) begin
                m_b0[k] = m_stage[2*k];
                m_b1[k] = m_stage[2*k+1];
            end
            m_cnt = 0;
        end
    endtask

    task automatic read_check(input bus_adr_t adr, input int expected, input string what);
        int waited;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = adr;
        wb_dat_i = '0;
        waited   = 0;
        do begin
            idle_cycle();
            waited++;
            if (waited > ACK_TIMEOUT) begin
                abort_run("Timeout: no bus ack for a read");
            end
        end while (!wb_ack_o);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        check_value(what, int'(wb_dat_o), expected);
    endtask

    task automatic load_random(input int n, input int span);
        int c;
        for (int j = 0; j < n; j++) begin
            c = int'($urandom_range(2 * span)) - span;
            bus_write(`ZF_ADR_COEF, {PADW'($urandom), coef_t'(c)});
        end
    endtask

    task automatic load_const(input int c);
        for (int j = 0; j < NCOEF; j++) begin
            bus_write(`ZF_ADR_COEF, {PADW'($urandom), coef_t'(c)});
        end
    endtask

    // Reserved bits random, update bit as given
    task automatic write_ctrl(input logic update);
        bus_write(`ZF_ADR_CTRL, {RSVW'($urandom), update});
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'hca386816));
        reset_i  = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        bypass_i = 1'b0;
        for (int i = 0; i < `ZF_NSAMP; i++) begin
            dat_i[i] = '0;
        end
        // Identity out of reset
        for (int k = 0; k < `ZF_NSAMP; k++) begin
            m_b0[k]          = 16384;
            m_b1[k]          = 0;
            m_stage[2*k]     = 16384;
            m_stage[2*k+1]   = 0;
        end
        m_hist = 0;
        m_cnt  = 0;

        repeat (4) @(posedge clk);
        #0.5;
        reset_i = 1'b0;

        // Identity filter
        run_random(60, 1'b0);

        // Random set, count read before and after update
        load_random(NCOEF, 16384);
        read_check(`ZF_ADR_CTRL, m_cnt, "write count before update");
        write_ctrl(1'b1);
        read_check(`ZF_ADR_CTRL, 0, "write count after update");
        repeat (4) idle_cycle();
        run_random(120, 1'b0);

        // Largest coefficient, full scale input
        load_const((1 << (`ZF_CBITS - 1)) - 1);
        write_ctrl(1'b1);
        repeat (4) idle_cycle();
        run_fullscale(10, 0);
        run_fullscale(10, 1);
        run_fullscale(20, 2);

        // Bypass per frame over a fresh set
        load_random(NCOEF, 16384);
        write_ctrl(1'b1);
        repeat (4) idle_cycle();
        run_random(120, 1'b1);

        // Staged writes stay inactive until update
        read_check(`ZF_ADR_CTRL, 0, "write count idle");
        load_random(3, 32768);
        repeat (4) idle_cycle();
        run_random(40, 1'b0);
        read_check(`ZF_ADR_CTRL, 3, "write count pending");
        read_check(7'h8, 0, "unmapped read");
        write_ctrl(1'b0);
        read_check(`ZF_ADR_CTRL, 3, "write count after no-op control");
        write_ctrl(1'b1);
        read_check(`ZF_ADR_CTRL, 0, "write count cleared");
        repeat (4) idle_cycle();
        run_random(40, 1'b0);

        // Flush the last real frames
        repeat (LAT + 1) idle_cycle();

        if (dut.u_assert.fail_cnt == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Bound checker reported assertion failures");
            $display("STATUS: FAIL");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

// File: flist.f
+incdir+hw
hw/coef_bus_pkg.sv
hw/sample_pkg.sv
hw/coef_regfile.sv
hw/zero_fir.sv
hw/output_shaper.sv
hw/zero_fir_top.sv
verification/zero_fir_assert.sv
verification/zero_fir_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the zero FIR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module zero_fir_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

out=$(./obj_dir/Vzero_fir_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only if the testbench printed its pass line
if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
echo "Pass line not found"
exit 1
